// ==== warb_pkg.sv ====
package warb_pkg;

  // number of requestors seen by the arbiter
  // this sizes reqs, the weight bus and the grant counter bank
  localparam int num_reqs = 4;

  // width of a winner index, enough to name every requestor
  localparam int winner_w = 2;

  // every weight is one byte, matching the width of the random value
  localparam int weight_w = 8;

  // grant counters saturate at all ones instead of wrapping
  localparam int cnt_w = 16;

  // APB address and data widths
  localparam int apb_aw = 8;
  localparam int apb_dw = 32;

  // weight registers start here, one word per requestor
  localparam logic [apb_aw-1:0] weight_base = 8'h00;

  // grant counters start here, one word per requestor
  // a write to any of them clears it whatever the data is
  localparam logic [apb_aw-1:0] cnt_base = 8'h40;

  // control register, bit 0 is count_en and all other bits must be written as 0
  localparam logic [apb_aw-1:0] ctrl_addr = 8'h80;

  // start value of the random generator, any nonzero value works
  localparam logic [7:0] lfsr_seed = 8'h5a;

  // Galois feedback mask for a right shifting register
  // x^8 + x^6 + x^5 + x^4 + 1 is primitive, so all 255 nonzero states appear
  localparam logic [7:0] lfsr_taps = 8'hb8;

endpackage

// ==== random08.sv ====
module random08 (
  input  logic       clk,
  input  logic       rst_n,
  output logic [7:0] random
);
  import warb_pkg::*;

  // current LFSR state and the state it moves to at the next edge
  logic [7:0] lfsr_q;
  logic [7:0] lfsr_nxt;

  // Galois form shifts right and folds the dropped bit back into the taps
  // the state can never become 0 because the seed is nonzero
  always_comb begin
    lfsr_nxt = {1'b0, lfsr_q[7:1]};
    if (lfsr_q[0]) begin
      lfsr_nxt = lfsr_nxt ^ lfsr_taps;
    end
  end

  // the register steps on every clock edge, there is no enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= lfsr_seed;
    end else begin
      lfsr_q <= lfsr_nxt;
    end
  end

  // the state itself is the random value
  // over 255 cycles every value from 1 to 255 shows up exactly once
  assign random = lfsr_q;

endmodule

// ==== strict_arb.sv ====
module strict_arb (
  input  logic [warb_pkg::num_reqs-1:0] reqs,
  output logic                          winner_v,
  output logic [warb_pkg::winner_w-1:0] winner
);
  import warb_pkg::*;

  // any request at all gives a valid winner
  assign winner_v = |reqs;

  // the loop runs from the highest index down to 0
  // so the last hit, the lowest requesting index, is the one that sticks
  // with no request the index stays at 0
  always_comb begin
    winner = '0;
    for (int i = num_reqs - 1; i >= 0; i--) begin
      if (reqs[i]) begin
        winner = winner_w'(i);
      end
    end
  end

endmodule

// ==== wrand_arb.sv ====
module wrand_arb (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [warb_pkg::num_reqs-1:0]                   reqs,
  input  logic [warb_pkg::num_reqs*warb_pkg::weight_w-1:0] cfg_weight,
  output logic                                            winner_v,
  output logic [warb_pkg::winner_w-1:0]                   winner
);
  import warb_pkg::*;

  // random value for this cycle, it moves on at every edge
  logic [7:0] random;

  // fallback result from the fixed priority arbiter
  logic                strict_winner_v;
  logic [winner_w-1:0] strict_winner;

  // candidate chosen from the weight bands and its registered copy
  logic [winner_w-1:0] cand_nxt;
  logic [winner_w-1:0] cand_q;

  random08 random08_i (
    .clk   (clk),
    .rst_n (rst_n),
    .random(random)
  );

  strict_arb strict_arb_i (
    .reqs    (reqs),
    .winner_v(strict_winner_v),
    .winner  (strict_winner)
  );

  // requestor i owns the values above weight[i-1] up to and including weight[i]
  // requestor 0 has no lower bound, so its band starts at the bottom
  // a weight of 0 shuts the requestor out of the random pick
  // later iterations overwrite earlier ones, so overlapping bands go to the higher index
  // when nothing matches the candidate falls back to 0
  always_comb begin
    cand_nxt = '0;
    for (int i = 0; i < num_reqs; i++) begin
      if (cfg_weight[i*weight_w +: weight_w] != '0 &&
          random <= cfg_weight[i*weight_w +: weight_w]) begin
        if (i == 0) begin
          cand_nxt = winner_w'(i);
        end else if (random > cfg_weight[(i-1)*weight_w +: weight_w]) begin
          cand_nxt = winner_w'(i);
        end
      end
    end
  end

  // the candidate is registered, so the grant uses last cycle's random value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cand_q <= '0;
    end else begin
      cand_q <= cand_nxt;
    end
  end

  // valid tracks the requests directly, the weights only decide who gets it
  assign winner_v = strict_winner_v;

  // the registered candidate wins if it is asking this cycle
  // otherwise the lowest requesting index takes the grant
  always_comb begin
    if (reqs[cand_q]) begin
      winner = cand_q;
    end else begin
      winner = strict_winner;
    end
  end

endmodule

// ==== arb_regs.sv ====
module arb_regs (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [warb_pkg::apb_aw-1:0]                      paddr,
  input  logic                                             psel,
  input  logic                                             penable,
  input  logic                                             pwrite,
  input  logic [warb_pkg::apb_dw-1:0]                      pwdata,
  output logic [warb_pkg::apb_dw-1:0]                      prdata,
  output logic                                             pready,
  output logic                                             pslverr,
  input  logic                                             winner_v,
  input  logic [warb_pkg::winner_w-1:0]                    winner,
  output logic [warb_pkg::num_reqs*warb_pkg::weight_w-1:0] cfg_weight
);
  import warb_pkg::*;

  // second phase of an APB transfer, the only cycle that does anything
  logic access;

  // address offsets relative to each register group
  logic [apb_aw-1:0] weight_off;
  logic [apb_aw-1:0] cnt_off;

  // group hits and the register index inside a group
  logic                weight_hit;
  logic                cnt_hit;
  logic                ctrl_hit;
  logic [winner_w-1:0] weight_idx;
  logic [winner_w-1:0] cnt_idx;

  // write strobes, only issued for transfers without an error
  logic wr_ok;
  logic weight_wr;
  logic cnt_clr;
  logic ctrl_wr;

  // control and counter state
  logic             count_en;
  logic [cnt_w-1:0] cnt_q [num_reqs];

  assign access = psel & penable;

  // subtracting the base makes an address below the group wrap to a large offset
  // which then fails the range test
  assign weight_off = paddr - weight_base;
  assign cnt_off    = paddr - cnt_base;

  // registers sit on word boundaries, one per requestor
  assign weight_hit = (weight_off[1:0] == 2'b00) && (weight_off[apb_aw-1:2] < num_reqs);
  assign cnt_hit    = (cnt_off[1:0] == 2'b00) && (cnt_off[apb_aw-1:2] < num_reqs);
  assign ctrl_hit   = (paddr == ctrl_addr);

  assign weight_idx = weight_off[2 +: winner_w];
  assign cnt_idx    = cnt_off[2 +: winner_w];

  // the error covers unmapped offsets and control writes with reserved bits set
  // it only shows up in the access cycle
  assign pslverr = access &
                   (~(weight_hit | cnt_hit | ctrl_hit) |
                    (ctrl_hit & pwrite & (|pwdata[apb_dw-1:1])));

  // there are no wait states
  assign pready = 1'b1;

  // a failed write leaves every register untouched
  assign wr_ok     = access & pwrite & ~pslverr;
  assign weight_wr = wr_ok & weight_hit;
  assign cnt_clr   = wr_ok & cnt_hit;
  assign ctrl_wr   = wr_ok & ctrl_hit;

  // weights live straight in the packed bus that feeds the arbiter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_weight <= '0;
      count_en   <= 1'b0;
    end else begin
      if (weight_wr) begin
        cfg_weight[weight_idx*weight_w +: weight_w] <= pwdata[weight_w-1:0];
      end
      if (ctrl_wr) begin
        count_en <= pwdata[0];
      end
    end
  end

  // one counter per requestor, bumped on each reported grant while counting is on
  // a clear from software beats an increment on the same edge
  // a full counter stays at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_reqs; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_reqs; i++) begin
        if (cnt_clr && cnt_idx == winner_w'(i)) begin
          cnt_q[i] <= '0;
        end else if (count_en && winner_v && winner == winner_w'(i) && cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // read data is driven only during a read access cycle
  // unmapped offsets read as 0
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (weight_hit) begin
        prdata = apb_dw'(cfg_weight[weight_idx*weight_w +: weight_w]);
      end else if (cnt_hit) begin
        prdata = apb_dw'(cnt_q[cnt_idx]);
      end else if (ctrl_hit) begin
        prdata = apb_dw'(count_en);
      end
    end
  end

endmodule

// ==== wrand_arb_top.sv ====
module wrand_arb_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [warb_pkg::apb_aw-1:0]   paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [warb_pkg::apb_dw-1:0]   pwdata,
  output logic [warb_pkg::apb_dw-1:0]   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic [warb_pkg::num_reqs-1:0] reqs,
  output logic                          winner_v,
  output logic [warb_pkg::winner_w-1:0] winner
);
  import warb_pkg::*;

  // weights programmed over APB, one byte per requestor
  logic [num_reqs*weight_w-1:0] cfg_weight;

  // register block, it also counts the grants it sees on winner
  arb_regs arb_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .winner_v  (winner_v),
    .winner    (winner),
    .cfg_weight(cfg_weight)
  );

  // the arbiter result goes out on the top ports and back into the counters
  // nothing accepts the grant, it is only reported
  wrand_arb wrand_arb_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .reqs      (reqs),
    .cfg_weight(cfg_weight),
    .winner_v  (winner_v),
    .winner    (winner)
  );

endmodule

// ==== wrand_arb_asserts.sv ====
module wrand_arb_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          psel,
  input logic                          penable,
  input logic                          pready,
  input logic                          pslverr,
  input logic [warb_pkg::num_reqs-1:0] reqs,
  input logic                          winner_v,
  input logic [warb_pkg::winner_w-1:0] winner
);
  timeunit 1ns;
  timeprecision 100ps;
  import warb_pkg::*;

  // a grant is reported exactly when somebody asks
  valid_is_or_of_reqs: assert property (
    @(posedge clk) disable iff (!rst_n) winner_v == |reqs
  ) else $error("winner_v differs from the OR of reqs");

  // the granted index must be one that is requesting
  winner_is_requesting: assert property (
    @(posedge clk) disable iff (!rst_n) winner_v |-> reqs[winner]
  ) else $error("winner points at an idle requestor");

  // the slave never inserts wait states
  ready_always_high: assert property (
    @(posedge clk) disable iff (!rst_n) pready
  ) else $error("pready dropped low");

  // errors only show up in the access cycle
  no_error_outside_access: assert property (
    @(posedge clk) disable iff (!rst_n) !(psel && penable) |-> !pslverr
  ) else $error("pslverr high outside an access cycle");

endmodule

bind wrand_arb_top wrand_arb_asserts wrand_arb_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .reqs    (reqs),
  .winner_v(winner_v),
  .winner  (winner)
);

// ==== tb_wrand_arb.sv ====
module tb_wrand_arb;
  timeunit 1ns;
  timeprecision 100ps;
  import warb_pkg::*;

  // cycles an APB transfer may spend waiting for pready
  localparam int ready_timeout = 16;

  // 32-bit Galois LFSR used for random request patterns
  localparam logic [31:0] rand_seed = 32'he0e8_85be;
  localparam logic [31:0] rand_mask = 32'h8020_0003;

  logic                clk;
  logic                rst_n;
  logic [apb_aw-1:0]   paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [apb_dw-1:0]   pwdata;
  logic [apb_dw-1:0]   prdata;
  logic                pready;
  logic                pslverr;
  logic [num_reqs-1:0] reqs;
  logic                winner_v;
  logic [winner_w-1:0] winner;

  // random state and the grant count model
  logic [31:0]      lfsr_state;
  logic             model_en;
  logic [cnt_w-1:0] model_cnt [num_reqs];

  // vector file handling
  int              fd;
  int              n;
  logic            done;
  logic [7:0]      cmd;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [31:0]     c;
  logic [8*256-1:0] line;

  wrand_arb_top wrand_arb_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .reqs    (reqs),
    .winner_v(winner_v),
    .winner  (winner)
  );

  always #5 clk = ~clk;

  // the model counts a grant at the falling edge, before the DUT counts it at the rising edge
  always @(negedge clk) begin
    if (rst_n && model_en && winner_v && model_cnt[winner] != '1) begin
      model_cnt[winner] = model_cnt[winner] + 1'b1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ rand_mask;
    end
    return s >> 1;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // moves to the falling edge of the access cycle, stretching it while pready is low
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
      cycles++;
      if (cycles > ready_timeout) begin
        abort_run("pready never went high during an APB access cycle");
      end
      @(negedge clk);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    int idx;
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1 penable = 1'b1;
    wait_ready();
    check($sformatf("pslverr on write to 0x%02h", addr), pslverr, exp_err);
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    // a good write to ctrl sets count_en, a good write to a counter clears it
    idx = (int'(addr) - int'(cnt_base)) / 4;
    if (!exp_err) begin
      if (addr == ctrl_addr) begin
        model_en = data[0];
      end
      if (addr[1:0] == 2'b00 && idx >= 0 && idx < num_reqs && addr >= cnt_base) begin
        model_cnt[idx] = '0;
      end
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1 penable = 1'b1;
    wait_ready();
    check($sformatf("prdata at 0x%02h", addr), prdata, exp_data);
    check($sformatf("pslverr on read of 0x%02h", addr), pslverr, exp_err);
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic drive_grant(input logic [num_reqs-1:0] r, input logic ev, input logic [1:0] ew);
    reqs = r;
    @(negedge clk);
    check("winner_v", winner_v, ev);
    check("winner", winner, ew);
    @(posedge clk);
    #1 reqs = '0;
  endtask

  // holds one pattern and expects every requesting index to win at least once
  task automatic hold_requests(input logic [num_reqs-1:0] r, input int count);
    int wins [num_reqs];
    for (int i = 0; i < num_reqs; i++) begin
      wins[i] = 0;
    end
    reqs = r;
    for (int k = 0; k < count; k++) begin
      @(negedge clk);
      check("winner_v", winner_v, |r);
      if (winner_v) begin
        check("reqs at winner", r[winner], 1'b1);
        wins[winner]++;
      end
      @(posedge clk);
      #1;
    end
    reqs = '0;
    for (int i = 0; i < num_reqs; i++) begin
      if (r[i]) begin
        check($sformatf("requestor %0d has won", i), wins[i] != 0, 1'b1);
      end
    end
  endtask

  task automatic random_requests(input int count);
    logic [num_reqs-1:0] r;
    for (int k = 0; k < count; k++) begin
      for (int bit_i = 0; bit_i < num_reqs; bit_i++) begin
        r[bit_i] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
      reqs = r;
      @(negedge clk);
      check("winner_v", winner_v, |r);
      if (winner_v) begin
        check("reqs at winner", r[winner], 1'b1);
      end
      @(posedge clk);
      #1;
    end
    reqs = '0;
  endtask

  task automatic compare_counters();
    for (int i = 0; i < num_reqs; i++) begin
      apb_read(cnt_base + 8'(4 * i), {16'h0, model_cnt[i]}, 1'b0);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    reqs = '0;
    lfsr_state = rand_seed;
    model_en = 1'b0;
    done = 1'b0;
    for (int i = 0; i < num_reqs; i++) begin
      model_cnt[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    fd = $fopen("wrand_arb_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open wrand_arb_vectors.txt");
    end
    while (!done) begin
      n = $fscanf(fd, " %c", cmd);
      if (n != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": n = $fgets(line, fd);
          "W": begin
            n = $fscanf(fd, "%h %h %h", a, b, c);
            apb_write(a[7:0], b, c[0]);
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", a, b, c);
            apb_read(a[7:0], b, c[0]);
          end
          "G": begin
            n = $fscanf(fd, "%h %h %h", a, b, c);
            drive_grant(a[num_reqs-1:0], b[0], c[1:0]);
          end
          "H": begin
            n = $fscanf(fd, "%h %h", a, b);
            hold_requests(a[num_reqs-1:0], int'(b));
          end
          "N": begin
            n = $fscanf(fd, "%h", a);
            random_requests(int'(a));
          end
          "K": compare_counters();
          default: abort_run($sformatf("unknown command %c in the vector file", cmd));
        endcase
      end
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== wrand_arb_vectors.txt ====
# all numbers hex: W addr data exp_pslverr | R addr exp_data exp_pslverr
# G reqs exp_winner_v exp_winner | H reqs cycles | N cycles | K checks all counters
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0c 00000000 0
R 40 00000000 0
R 44 00000000 0
R 48 00000000 0
R 4c 00000000 0
R 80 00000000 0
# all weights 0 gives plain strict priority
G 0 0 0
G f 1 0
G e 1 1
G c 1 2
G 8 1 3
# weight0 at 255 owns every random value
W 00 000000ff 0
R 00 000000ff 0
G f 1 0
G 9 1 0
G 6 1 1
G c 1 2
G 8 1 3
# four equal bands, 0xc0 to 0xff belongs to requestor 3
W 00 0000003f 0
W 04 0000007f 0
W 08 000000bf 0
W 0c 000000ff 0
G 1 1 0
G 2 1 1
G 4 1 2
G 8 1 3
H f ff
# grant counting with count_en set, then a clear, then counting off
W 80 00000001 0
R 80 00000001 0
N 200
K
W 44 00005a5a 0
R 44 00000000 0
K
W 80 00000000 0
N 100
K
# unmapped and illegal accesses
R 50 00000000 1
W 50 12345678 1
R 41 00000000 1
W 80 00000003 1
R 80 00000000 0
R 00 0000003f 0
R 0c 000000ff 0
K

// ==== project.f ====
warb_pkg.sv
random08.sv
strict_arb.sv
wrand_arb.sv
arb_regs.sv
wrand_arb_top.sv
wrand_arb_asserts.sv
tb_wrand_arb.sv

// ==== run.sh ====
#!/bin/sh
# compiles the testbench and RTL with Verilator and runs the simulation
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_wrand_arb -f project.f -o sim_wrand_arb

# the verdict comes from the log, not from the exit status
./obj_dir/sim_wrand_arb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
